//--- tb/muldiv_golden.txt
# Vector count in decimal, then one vector per line with all fields in hex:
# operation code (0 mul .. 7 remu), operand1, operand2, expected result
42
0 00000007 00000003 00000015
4 00000014 00000006 00000003
0 FFFFFFFF 00000005 FFFFFFFB
4 FFFFFFEC 00000006 FFFFFFFD
0 80000000 FFFFFFFF 80000000
4 00000014 FFFFFFFA FFFFFFFD
0 00010001 00010001 00020001
4 FFFFFFEC FFFFFFFA 00000003
0 00000000 FFFFFFFF 00000000
6 00000014 00000006 00000002
0 0000FFFF 0000FFFF FFFE0001
6 FFFFFFEC 00000006 FFFFFFFE
1 FFFFFFFF FFFFFFFF 00000000
6 00000014 FFFFFFFA 00000002
1 80000000 80000000 40000000
6 FFFFFFEC FFFFFFFA FFFFFFFE
1 7FFFFFFF 7FFFFFFF 3FFFFFFF
5 FFFFFFEC 00000006 2AAAAAA7
1 80000000 7FFFFFFF C0000000
7 FFFFFFEC 00000006 00000002
1 FFFFFFFE 00000003 FFFFFFFF
5 00000064 00000007 0000000E
2 FFFFFFFF FFFFFFFF FFFFFFFF
7 00000064 00000007 00000002
2 80000000 FFFFFFFF 80000000
5 FFFFFFFF FFFFFFFF 00000001
2 7FFFFFFF FFFFFFFF 7FFFFFFE
7 00000005 80000000 00000005
2 00000000 FFFFFFFF 00000000
4 12345678 00000000 FFFFFFFF
3 FFFFFFFF FFFFFFFF FFFFFFFE
5 00000000 00000000 FFFFFFFF
3 80000000 00000002 00000001
6 FFFFFF85 00000000 FFFFFF85
3 12345678 00010000 00001234
7 12345678 00000000 12345678
3 FFFFFFFF 00000000 00000000
4 80000000 FFFFFFFF 80000000
6 80000000 FFFFFFFF 00000000
4 7FFFFFFF 00000002 3FFFFFFF
7 FFFFFFFF 00000010 0000000F
5 80000000 00000001 80000000

//--- muldiv_unit.f
design/common.sv
design/divider.sv
design/multiplier.sv
design/muldiv_unit.sv
tb/clock_gen.sv
tb/muldiv_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the muldiv unit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert \
    --top-module muldiv_unit_tb \
    --Mdir "$build_dir" -o muldiv_sim \
    -f muldiv_unit.f > "$build_log" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$build_log"
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$build_dir/muldiv_sim" > "$sim_log" 2>&1
status=$?
cat "$sim_log"

# The log decides the outcome
if grep -q "TESTS FAILED" "$sim_log"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
if ! grep -q "TESTS PASSED" "$sim_log"; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0

//--- tb/muldiv_unit_tb.sv
`timescale 1ns/100ps

module muldiv_unit_tb;

    localparam int xlen_width    = common::xlen_width;
    localparam int clk_period_ns = 20;
    localparam int reset_cycles  = 16;
    localparam int max_gap       = 8;
    localparam int drive_delay   = 2;

    logic                  clk;
    logic                  reset_n;
    logic                  start;
    common::alu_op_type    operation;
    logic [xlen_width-1:0] operand1;
    logic [xlen_width-1:0] operand2;
    logic [xlen_width-1:0] result;
    logic                  ready;
    logic                  done;

    logic [3:0]            vec_op[$];
    logic [xlen_width-1:0] vec_a[$];
    logic [xlen_width-1:0] vec_b[$];
    logic [xlen_width-1:0] vec_expected[$];
    int                    vector_count;
    bit                    vectors_loaded;
    integer                seed;

    clock_gen #(
        .period_ns    (clk_period_ns),
        .reset_cycles (reset_cycles)
    ) i_clock_gen (
        .clk     (clk),
        .reset_n (reset_n)
    );

    muldiv_unit #(
        .xlen_width (xlen_width)
    ) i_muldiv_unit (
        .clk       (clk),
        .reset_n   (reset_n),
        .start     (start),
        .operation (operation),
        .operand1  (operand1),
        .operand2  (operand2),
        .result    (result),
        .ready     (ready),
        .done      (done)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("** Error: %s mismatch, expected 0x%0h, actual 0x%0h",
                                name, expected, actual));
        end
    endtask

    task automatic load_vectors();
        int                    fd;
        int                    fields;
        string                 line;
        bit                    have_count;
        logic [3:0]            op;
        logic [xlen_width-1:0] a;
        logic [xlen_width-1:0] b;
        logic [xlen_width-1:0] expected;
        fd = $fopen("tb/muldiv_golden.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open tb/muldiv_golden.txt");
        end
        have_count = 1'b0;
        while ($fgets(line, fd) != 0) begin
            if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n") begin
                continue;
            end
            if (!have_count) begin
                fields = $sscanf(line, "%d", vector_count);
                if (fields != 1) begin
                    abort_run("golden file has no vector count");
                end
                have_count = 1'b1;
            end else begin
                fields = $sscanf(line, "%h %h %h %h", op, a, b, expected);
                if (fields != 4) begin
                    abort_run({"malformed golden line: ", line});
                end
                vec_op.push_back(op);
                vec_a.push_back(a);
                vec_b.push_back(b);
                vec_expected.push_back(expected);
            end
        end
        $fclose(fd);
        if (vec_op.size() != vector_count) begin
            abort_run("golden vector count does not match the lines in the file");
        end
    endtask

    // Entered 2 ns after a rising edge, left 2 ns after the edge that ends the done cycle
    task automatic run_vector(input int idx);
        int    latency;
        string tag;
        tag = $sformatf("vector %0d", idx);
        check_value({tag, " ready"}, 64'(ready), 64'(1));
        start     = 1'b1;
        operation = common::alu_op_type'(vec_op[idx]);
        operand1  = vec_a[idx];
        operand2  = vec_b[idx];
        @(posedge clk);
        #(drive_delay);
        start   = 1'b0;
        latency = 0;
        @(negedge clk);
        while (!done) begin
            check_value({tag, " ready"}, 64'(ready), 64'(0));
            @(posedge clk);
            latency++;
            @(negedge clk);
        end
        // Edges counted from the start edge to the one that raises done
        check_value({tag, " done latency"}, 64'(latency), 64'(xlen_width + 2));
        check_value({tag, " ready"}, 64'(ready), 64'(0));
        check_value({tag, " result"}, 64'(result), 64'(vec_expected[idx]));
        @(posedge clk);
        #(drive_delay);
        check_value({tag, " done"}, 64'(done), 64'(0));
        check_value({tag, " ready"}, 64'(ready), 64'(1));
    endtask

    initial begin
        int gap;
        seed           = 32'h1583261b;
        start          = 1'b0;
        operation      = common::alu_mul;
        operand1       = '0;
        operand2       = '0;
        vectors_loaded = 1'b0;
        load_vectors();
        vectors_loaded = 1'b1;
        wait (reset_n === 1'b1);
        @(posedge clk);
        #(drive_delay);
        check_value("ready after reset", 64'(ready), 64'(1));
        check_value("done after reset", 64'(done), 64'(0));
        for (int i = 0; i < vector_count; i++) begin
            run_vector(i);
            // Every third vector starts in the cycle right after done
            if (i % 3 == 2) begin
                gap = 0;
            end else begin
                gap = int'($unsigned($random(seed)) % (max_gap + 1));
            end
            repeat (gap) begin
                @(posedge clk);
                #(drive_delay);
            end
        end
        $display("TESTS PASSED");
        $finish;
    end

    initial begin
        longint limit_ns;
        wait (vectors_loaded);
        // Margin covers the start cycle and post-done cycle of each vector
        limit_ns = longint'(vector_count) * (xlen_width + 2 + max_gap) * clk_period_ns
                 + reset_cycles * clk_period_ns
                 + (longint'(vector_count) * 4 + 100) * clk_period_ns;
        #(limit_ns);
        abort_run($sformatf("run timed out after %0d ns", limit_ns));
    end

endmodule

//--- tb/clock_gen.sv
`timescale 1ns/100ps

module clock_gen #(
    parameter int period_ns    = 20,
    parameter int reset_cycles = 16
) (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2) clk = ~clk;
        end
    end

    // Reset leaves a little after a rising edge, clear of the clock
    initial begin
        reset_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #2 reset_n = 1'b1;
    end

endmodule

//--- design/muldiv_unit.sv
`timescale 1ns/100ps

module muldiv_unit #(
    parameter int xlen_width = common::xlen_width
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  start,
    input  common::alu_op_type    operation,
    input  logic [xlen_width-1:0] operand1,
    input  logic [xlen_width-1:0] operand2,
    output logic [xlen_width-1:0] result,
    output logic                  ready,
    output logic                  done
);

    logic                  busy;
    logic                  active_is_div;
    logic                  op_is_div;
    logic                  accept;
    logic                  div_start;
    logic                  mul_start;
    logic                  div_next_ready;
    logic                  mul_next_ready;
    logic [xlen_width-1:0] div_result;
    logic [xlen_width-1:0] mul_result;

    assign op_is_div = common::is_div_op(operation);
    assign accept    = start && !busy;
    assign div_start = accept && op_is_div;
    assign mul_start = accept && !op_is_div;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy          <= 1'b0;
            active_is_div <= 1'b0;
        end else if (accept) begin
            busy          <= 1'b1;
            active_is_div <= op_is_div;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    assign done   = busy && (active_is_div ? div_next_ready : mul_next_ready);
    assign result = active_is_div ? div_result : mul_result;
    assign ready  = !busy;

    divider #(
        .xlen_width (xlen_width)
    ) i_divider (
        .clk        (clk),
        .reset_n    (reset_n),
        .start      (div_start),
        .operation  (operation),
        .operand1   (operand1),
        .operand2   (operand2),
        .result     (div_result),
        .next_ready (div_next_ready)
    );

    multiplier #(
        .xlen_width (xlen_width)
    ) i_multiplier (
        .clk        (clk),
        .reset_n    (reset_n),
        .start      (mul_start),
        .operation  (operation),
        .operand1   (operand1),
        .operand2   (operand2),
        .result     (mul_result),
        .next_ready (mul_next_ready)
    );

    a_no_start_while_busy: assert property (
        @(posedge clk) disable iff (!reset_n)
        start |-> !busy
    ) else $error("start while muldiv unit busy");

    // Units read operation until their result is taken
    a_operation_stable: assert property (
        @(posedge clk) disable iff (!reset_n)
        busy |-> $stable(operation)
    ) else $error("operation changed while muldiv unit busy");

    // A unit never answers in the cycle its start is accepted
    a_done_after_busy: assert property (
        @(posedge clk) disable iff (!reset_n)
        done |-> $past(busy)
    ) else $error("done in the cycle a start was accepted");

endmodule

//--- design/multiplier.sv
`timescale 1ns/100ps

module multiplier #(
    parameter int xlen_width = common::xlen_width
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  start,
    input  common::alu_op_type    operation,
    input  logic [xlen_width-1:0] operand1,
    input  logic [xlen_width-1:0] operand2,
    output logic [xlen_width-1:0] result,
    output logic                  next_ready
);

    localparam int cnt_width = $clog2(xlen_width + 1);

    typedef enum logic [1:0] {
        state_idle,
        state_calc,
        state_done
    } state_type;

    state_type state, next_state;

    logic [cnt_width-1:0]    bit_cnt;
    logic                    op1_signed;
    logic                    op2_signed;
    logic                    op1_neg;
    logic                    op2_neg;
    logic [xlen_width-1:0]   multiplicand;
    // Upper half accumulates, lower half holds the multiplier bits still to use
    logic [2*xlen_width-1:0] product;
    logic [xlen_width:0]     sum;
    logic [2*xlen_width-1:0] product_signed;
    logic                    result_valid;
    logic                    ready_d;

    assign op1_signed = operation == common::alu_mul || operation == common::alu_mulh ||
                        operation == common::alu_mulhsu;
    assign op2_signed = operation == common::alu_mul || operation == common::alu_mulh;

    always_comb begin
        case (state)
            state_idle: next_state = start ? state_calc : state_idle;
            state_calc: next_state = (bit_cnt == cnt_width'(1)) ? state_done : state_calc;
            state_done: next_state = ready_d ? state_idle : state_done;
            default:    next_state = state_idle;
        endcase
    end

    assign sum = {1'b0, product[2*xlen_width-1:xlen_width]} +
                 (product[0] ? {1'b0, multiplicand} : '0);

    assign product_signed = (op1_neg ^ op2_neg) ? -product : product;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state        <= state_idle;
            bit_cnt      <= '0;
            result_valid <= 1'b0;
            ready_d      <= 1'b0;
        end else begin
            state <= next_state;
            case (state)
                state_idle: begin
                    result_valid <= 1'b0;
                    ready_d      <= 1'b0;
                    if (start) begin
                        bit_cnt <= cnt_width'(xlen_width);
                    end
                end
                state_calc: begin
                    bit_cnt <= bit_cnt - 1'b1;
                end
                state_done: begin
                    result_valid <= 1'b1;
                    ready_d      <= result_valid;
                end
                default: begin
                    bit_cnt <= '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == state_idle && start) begin
            op1_neg      <= op1_signed && operand1[xlen_width-1];
            op2_neg      <= op2_signed && operand2[xlen_width-1];
            multiplicand <= (op1_signed && operand1[xlen_width-1]) ? -operand1 : operand1;
            product      <= {{xlen_width{1'b0}},
                             (op2_signed && operand2[xlen_width-1]) ? -operand2 : operand2};
        end else if (state == state_calc) begin
            product <= {sum, product[xlen_width-1:1]};
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            result <= '0;
        end else if (state == state_done && !result_valid) begin
            if (operation == common::alu_mul)
                result <= product_signed[xlen_width-1:0];
            else
                result <= product_signed[2*xlen_width-1:xlen_width];
        end
    end

    assign next_ready = (state == state_idle && !start) || (state == state_done && ready_d);

    // Ready stays low through the calculation and the edge that registers result
    a_no_ready_in_calc: assert property (
        @(posedge clk) disable iff (!reset_n)
        state == state_calc |=> !next_ready
    ) else $error("multiplier ready before result registered");

endmodule

//--- design/divider.sv
`timescale 1ns/100ps

module divider #(
    parameter int xlen_width = common::xlen_width
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  start,
    input  common::alu_op_type    operation,
    input  logic [xlen_width-1:0] operand1,
    input  logic [xlen_width-1:0] operand2,
    output logic [xlen_width-1:0] result,
    output logic                  next_ready
);

    localparam int cnt_width = $clog2(xlen_width + 1);

    typedef enum logic [1:0] {
        state_idle,
        state_calc,
        state_done
    } state_type;

    state_type state, next_state;

    logic [cnt_width-1:0]  bit_cnt;
    logic                  is_signed;
    logic                  dividend_sign;
    logic                  divisor_sign;
    logic                  divisor_zero;
    // Dividend bits leave at the top while quotient bits enter at the bottom
    logic [xlen_width-1:0] dividend;
    logic [xlen_width-1:0] divisor;
    logic [xlen_width-1:0] remainder;
    logic [xlen_width-1:0] operand1_q;
    logic [xlen_width:0]   partial;
    logic [xlen_width:0]   difference;
    logic                  quotient_bit;
    logic [xlen_width-1:0] quotient_signed;
    logic [xlen_width-1:0] remainder_signed;
    logic                  result_valid;
    logic                  ready_d;

    always_comb begin
        case (operation)
            common::alu_div, common::alu_rem: is_signed = 1'b1;
            default:                          is_signed = 1'b0;
        endcase
    end

    always_comb begin
        case (state)
            state_idle: next_state = start ? state_calc : state_idle;
            state_calc: next_state = (bit_cnt == cnt_width'(1)) ? state_done : state_calc;
            state_done: next_state = ready_d ? state_idle : state_done;
            default:    next_state = state_idle;
        endcase
    end

    // One restoring step
    assign partial      = {remainder, dividend[xlen_width-1]};
    assign difference   = partial - {1'b0, divisor};
    assign quotient_bit = partial >= {1'b0, divisor};

    assign quotient_signed  = (dividend_sign ^ divisor_sign) ? -dividend : dividend;
    assign remainder_signed = dividend_sign ? -remainder : remainder;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state        <= state_idle;
            bit_cnt      <= '0;
            result_valid <= 1'b0;
            ready_d      <= 1'b0;
        end else begin
            state <= next_state;
            case (state)
                state_idle: begin
                    result_valid <= 1'b0;
                    ready_d      <= 1'b0;
                    if (start) begin
                        bit_cnt <= cnt_width'(xlen_width);
                    end
                end
                state_calc: begin
                    bit_cnt <= bit_cnt - 1'b1;
                end
                state_done: begin
                    // Result lands on the first done edge, ready on the second
                    result_valid <= 1'b1;
                    ready_d      <= result_valid;
                end
                default: begin
                    bit_cnt <= '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == state_idle && start) begin
            operand1_q    <= operand1;
            divisor_zero  <= operand2 == '0;
            dividend_sign <= is_signed && operand1[xlen_width-1];
            divisor_sign  <= is_signed && operand2[xlen_width-1];
            dividend      <= (is_signed && operand1[xlen_width-1]) ? -operand1 : operand1;
            divisor       <= (is_signed && operand2[xlen_width-1]) ? -operand2 : operand2;
            remainder     <= '0;
        end else if (state == state_calc) begin
            remainder <= quotient_bit ? difference[xlen_width-1:0] : partial[xlen_width-1:0];
            dividend  <= {dividend[xlen_width-2:0], quotient_bit};
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            result <= '0;
        end else if (state == state_done && !result_valid) begin
            // Min negative over -1 wraps back to min negative in the negation
            case (operation)
                common::alu_div, common::alu_divu:
                    result <= divisor_zero ? {xlen_width{1'b1}} : quotient_signed;
                common::alu_rem, common::alu_remu:
                    result <= divisor_zero ? operand1_q : remainder_signed;
                default:
                    result <= '0;
            endcase
        end
    end

    assign next_ready = (state == state_idle && !start) || (state == state_done && ready_d);

    a_bit_cnt_no_underflow: assert property (
        @(posedge clk) disable iff (!reset_n)
        state == state_calc |-> bit_cnt != '0
    ) else $error("divider bit counter underflow");

endmodule

//--- design/common.sv
package common;

    // Data word width of the integer core
    localparam int xlen_width = 32;

    // M-extension operations, codes are fixed
    typedef enum logic [3:0] {
        alu_mul    = 4'd0,
        alu_mulh   = 4'd1,
        alu_mulhsu = 4'd2,
        alu_mulhu  = 4'd3,
        alu_div    = 4'd4,
        alu_divu   = 4'd5,
        alu_rem    = 4'd6,
        alu_remu   = 4'd7
    } alu_op_type;

    // Divide and remainder codes sit at 4 and above
    function automatic logic is_div_op(alu_op_type op);
        return op >= alu_div;
    endfunction

endpackage
